/* rv_exec_pkg.sv */
// Shared RV64 widths, opcode encodings, decode structs and FSM states, imported by the design.
`default_nettype none

package rv_exec_pkg;

    // Architectural data width.
    typedef logic [63:0] xlen_t;

    // Raw instruction word.
    typedef logic [31:0] instr_t;

    // Register index, x0 to x31.
    typedef logic [4:0] reg_idx_t;

    // Major opcode field, instr[6:0].
    typedef logic [6:0] opcode_t;

    // Function select, instr[14:12].
    typedef logic [2:0] funct3_t;

    // Register-immediate ALU ops.
    localparam opcode_t OP_ALRI = 7'b0010011;
    // Register-register ALU ops.
    localparam opcode_t OP_ALRR = 7'b0110011;
    // Word-sized register-immediate ops.
    localparam opcode_t OP_ALRIW = 7'b0011011;
    // Word-sized register-register ops.
    localparam opcode_t OP_ALRRW = 7'b0111011;
    // Load upper immediate.
    localparam opcode_t OP_LUI = 7'b0110111;

    // Controls handed to the ALU.
    // Mod picks SUB in OP forms and SRA in all shifts.
    typedef struct packed {
        opcode_t opcode;
        funct3_t op;
        logic    mod;
    } alu_ctrl_t;

    // Fully decoded instruction.
    typedef struct packed {
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        // Already sign-extended, shifted for LUI.
        xlen_t     imm;
        // Operand b from imm instead of rs2.
        logic      use_imm;
        alu_ctrl_t ctrl;
        // Supported opcode with rd other than x0.
        logic      wr_en;
    } dec_instr_t;

    // Execute sequencer states.
    typedef enum logic [1:0] {
        IDLE,
        OPERANDS,
        RESULT,
        DONE
    } exec_state_t;

endpackage

`default_nettype wire

/* alu.sv */
// Combinational RV64I ALU, used by the execute unit on registered operands.
`timescale 1ns/1ns
`default_nettype none

module alu import rv_exec_pkg::*; (
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   alu_out,
    input  opcode_t opcode,
    input  funct3_t op,
    input  logic    mod
);

    // Word form flag, opcode bit 3.
    logic w;
    // Subtract only for the register-register forms.
    logic mod_sub;
    xlen_t op1;
    xlen_t op2;
    logic [5:0] shamt;

    // Per-function results.
    xlen_t d_add;
    xlen_t d_sll;
    xlen_t d_slt;
    xlen_t d_sltu;
    xlen_t d_xor;
    xlen_t d_or;
    xlen_t d_and;

    // Right shift variants.
    xlen_t srl_d;
    xlen_t sra_d;
    logic [31:0] srl_w;
    logic [31:0] sra_w;
    xlen_t shr_d;
    logic [31:0] shr_w;
    xlen_t d_shr;

    // Result and upper-half muxes, indexed by op.
    xlen_t res_mux [8];
    logic [31:0] ext_mux [8];

    assign w       = opcode[3];
    assign mod_sub = mod & opcode[5];

    // Word forms see sign-extended low halves.
    assign op1 = w ? {{32{a[31]}}, a[31:0]} : a;
    assign op2 = w ? {{32{b[31]}}, b[31:0]} : b;

    // Six-bit amount, bit 5 dropped for word forms.
    assign shamt = {op2[5] & ~w, op2[4:0]};

    assign d_add  = mod_sub ? op1 - op2 : op1 + op2;
    assign d_sll  = op1 << shamt;
    assign d_slt  = {63'b0, $signed(op1) < $signed(op2)};
    assign d_sltu = {63'b0, op1 < op2};
    assign d_xor  = op1 ^ op2;
    assign d_or   = op1 | op2;
    assign d_and  = op1 & op2;

    // Shift from the raw operands.
    // Kept in separate assigns so the arithmetic shifts stay signed.
    assign srl_d = a >> shamt;
    assign sra_d = $signed(a) >>> shamt;
    assign srl_w = a[31:0] >> shamt;
    assign sra_w = $signed(a[31:0]) >>> shamt;

    assign shr_d = mod ? sra_d : srl_d;
    assign shr_w = mod ? sra_w : srl_w;
    assign d_shr = w ? {32'b0, shr_w} : shr_d;

    // Low result per function.
    assign res_mux[0] = d_add;
    assign res_mux[1] = d_sll;
    assign res_mux[2] = d_slt;
    assign res_mux[3] = d_sltu;
    assign res_mux[4] = d_xor;
    assign res_mux[5] = d_shr;
    assign res_mux[6] = d_or;
    assign res_mux[7] = d_and;

    // Upper half, sign of bit 31 for word forms.
    assign ext_mux[0] = w ? {32{d_add[31]}} : d_add[63:32];
    assign ext_mux[1] = w ? {32{d_sll[31]}} : d_sll[63:32];
    assign ext_mux[2] = 32'b0;
    assign ext_mux[3] = 32'b0;
    assign ext_mux[4] = d_xor[63:32];
    assign ext_mux[5] = w ? {32{shr_w[31]}} : shr_d[63:32];
    assign ext_mux[6] = d_or[63:32];
    assign ext_mux[7] = d_and[63:32];

    always_comb begin
        case (opcode)
            OP_ALRI, OP_ALRR, OP_ALRIW, OP_ALRRW: begin
                alu_out = {ext_mux[op], res_mux[op][31:0]};
            end
            // Upper immediate passes straight through.
            OP_LUI:  alu_out = b;
            default: alu_out = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* rv_decode.sv */
// Combinational decoder from a RISC-V instruction word to register indices, immediate and ALU controls.
`timescale 1ns/1ns
`default_nettype none

module rv_decode import rv_exec_pkg::*; (
    input  instr_t     instr,
    output dec_instr_t dec
);

    opcode_t opcode;
    reg_idx_t rd;
    // I-type immediate, bits 31:20.
    xlen_t imm_i;
    // U-type immediate, bits 31:12 shifted up by 12.
    xlen_t imm_u;
    // One of the five executed opcodes.
    logic supported;
    // Operand b comes from the immediate.
    logic imm_form;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OP_ALRI, OP_ALRR, OP_ALRIW, OP_ALRRW, OP_LUI: supported = 1'b1;
            default: supported = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ALRI, OP_ALRIW, OP_LUI: imm_form = 1'b1;
            default: imm_form = 1'b0;
        endcase
    end

    always_comb begin
        // Field positions.
        dec.rd  = rd;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];

        // Immediate by format.
        if (opcode == OP_LUI) begin
            dec.imm = imm_u;
        end else begin
            dec.imm = imm_i;
        end
        dec.use_imm = imm_form;

        // ALU controls.
        // Mod is bit 30, for both SUB and SRA/SRAI.
        dec.ctrl.opcode = opcode;
        dec.ctrl.op     = instr[14:12];
        dec.ctrl.mod    = instr[30];

        // Unsupported opcodes and rd = x0 write nothing.
        dec.wr_en = supported && (rd != '0);
    end

endmodule

`default_nettype wire

/* rv_regfile.sv */
// Architectural register file with x0 tied to zero, shared by the bus host and the writeback path.
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_exec_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t host_idx,
    input  reg_idx_t wb_idx,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    output xlen_t    host_rdata,
    input  logic     host_we,
    input  logic     wb_we,
    input  xlen_t    host_wdata,
    input  xlen_t    wb_data
);

    // Storage for x1..x31 only.
    xlen_t regs [1:31];

    // Host and writeback never collide.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_we && host_idx != '0) begin
                regs[host_idx] <= host_wdata;
            end
            if (wb_we && wb_idx != '0) begin
                regs[wb_idx] <= wb_data;
            end
        end
    end

    // Read ports with x0 returning zero.
    assign rs1_data   = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data   = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    assign host_rdata = (host_idx == '0) ? '0 : regs[host_idx];

endmodule

`default_nettype wire

/* rv_exec_unit.sv */
// Execute sequencer that decodes one instruction, runs the ALU and writes the result back.
`timescale 1ns/1ns
`default_nettype none

module rv_exec_unit import rv_exec_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  instr_t   instr,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     wb_we,
    output reg_idx_t wb_idx,
    output xlen_t    wb_data,
    output logic     done
);

    exec_state_t state;
    // Instruction held for the whole execution.
    instr_t instr_q;
    // Decode of instr_q, live during OPERANDS.
    dec_instr_t dec;
    dec_instr_t dec_q;
    xlen_t op_a_q;
    xlen_t op_b_q;
    xlen_t alu_out;
    xlen_t res_q;

    // Fixed four-state walk.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (start) state <= OPERANDS;
                OPERANDS: state <= RESULT;
                RESULT:   state <= DONE;
                DONE:     state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Payload registers, loaded per state.
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            instr_q <= instr;
        end
        if (state == OPERANDS) begin
            dec_q <= dec;
            // LUI adds nothing to the immediate.
            op_a_q <= (dec.ctrl.opcode == OP_LUI) ? '0 : rs1_data;
            op_b_q <= dec.use_imm ? dec.imm : rs2_data;
        end
        if (state == RESULT) begin
            res_q <= alu_out;
        end
    end

    rv_decode u_decode (
        .instr (instr_q),
        .dec   (dec)
    );

    // Register file ports follow the stored instruction.
    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    alu u_alu (
        .a       (op_a_q),
        .b       (op_b_q),
        .alu_out (alu_out),
        .opcode  (dec_q.ctrl.opcode),
        .op      (dec_q.ctrl.op),
        .mod     (dec_q.ctrl.mod)
    );

    // Writeback in the DONE cycle.
    assign wb_we   = (state == DONE) && dec_q.wr_en;
    assign wb_idx  = dec_q.rd;
    assign wb_data = res_q;
    assign done    = (state == DONE);

endmodule

`default_nettype wire

/* rv_wb_slave.sv */
// Wishbone classic slave that maps register accesses and instruction writes onto the execute engine.
`timescale 1ns/1ns
`default_nettype none

module rv_wb_slave import rv_exec_pkg::*; #(
    parameter int ADR_W     = 6,
    parameter int INSTR_ADR = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  xlen_t            dat_w,
    output xlen_t            dat_r,
    output logic             ack,
    output logic             host_we,
    output reg_idx_t         host_idx,
    output xlen_t            host_wdata,
    input  xlen_t            host_rdata,
    output logic             start,
    output instr_t           instr,
    input  logic             done
);

    // Execution in flight.
    logic busy;
    // New transfer, not the tail of an acked one.
    logic req;
    logic is_reg;
    logic is_instr;

    assign req      = cyc && stb && !ack && !busy;
    assign is_reg   = (adr < ADR_W'(32));
    assign is_instr = (adr == ADR_W'(INSTR_ADR));

    // Register port straight from the bus.
    assign host_we    = req && we && is_reg;
    assign host_idx   = adr[4:0];
    assign host_wdata = dat_w;

    // Instruction launch, low word only.
    assign start = req && we && is_instr;
    assign instr = dat_w[31:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            ack <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (req) begin
                // Single-cycle ack, unmapped reads as zero.
                ack   <= 1'b1;
                dat_r <= is_reg ? host_rdata : '0;
            end else if (busy && done) begin
                // Ack the instruction write after writeback.
                busy  <= 1'b0;
                ack   <= 1'b1;
                dat_r <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_exec_top.sv */
// Top level of the RV64I execute engine, exposing the Wishbone slave port to the host.
`timescale 1ns/1ns
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; #(
    parameter int ADR_W     = 6,
    parameter int INSTR_ADR = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  xlen_t            dat_w,
    output xlen_t            dat_r,
    output logic             ack
);

    // Host register port.
    logic     host_we;
    reg_idx_t host_idx;
    xlen_t    host_wdata;
    xlen_t    host_rdata;

    // Execute handshake.
    logic   start;
    instr_t instr;
    logic   done;

    // Operand reads and writeback.
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     wb_we;
    reg_idx_t wb_idx;
    xlen_t    wb_data;

    rv_wb_slave #(
        .ADR_W     (ADR_W),
        .INSTR_ADR (INSTR_ADR)
    ) u_wb_slave (
        .clk        (clk),
        .arst_n     (arst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .host_we    (host_we),
        .host_idx   (host_idx),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .start      (start),
        .instr      (instr),
        .done       (done)
    );

    rv_exec_unit u_exec_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .instr    (instr),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_idx   (wb_idx),
        .wb_data  (wb_data),
        .done     (done)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .host_idx   (host_idx),
        .wb_idx     (wb_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .host_rdata (host_rdata),
        .host_we    (host_we),
        .wb_we      (wb_we),
        .host_wdata (host_wdata),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

/* tb_rv_exec.sv */
// Self-checking testbench for the RV64I execute engine, driving random Wishbone traffic.
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam int ADR_W      = 6;
    localparam int INSTR_ADR  = 32;
    localparam int CLK_PERIOD = 100;
    // Random instructions per ALU test.
    localparam int N_RND      = 200;
    localparam int N_LUI      = 20;
    localparam int N_BAD      = 6;
    // Upper bound on bus transfers over the whole run.
    localparam int N_XFER     = 64 + 2 * (N_RND + N_RND / 8 + 32) + (N_LUI + 5 + 32)
                                + (N_BAD + 63 + 32);
    localparam int WATCHDOG_NS = (N_XFER * 10 + 100) * CLK_PERIOD;

    logic             clk;
    logic             arst_n;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    xlen_t            dat_w;
    xlen_t            dat_r;
    logic             ack;

    // Expected architectural state.
    xlen_t model_regs [32];
    logic [31:0] lcg_state;

    rv_exec_top #(
        .ADR_W     (ADR_W),
        .INSTR_ADR (INSTR_ADR)
    ) UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: a bus transfer never completed");
        $display("TEST FAILED");
        $fatal(1);
    end

    // LCG step, high bits folded into the weak low bits.
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // Expected result of one supported instruction.
    function automatic xlen_t ref_exec(input instr_t ins, input xlen_t rs1v, input xlen_t rs2v);
        opcode_t opc;
        logic [2:0] f3;
        logic m;
        logic word;
        logic [5:0] sh;
        xlen_t x;
        xlen_t y;
        xlen_t r;
        opc  = ins[6:0];
        f3   = ins[14:12];
        m    = ins[30];
        word = (opc == OP_ALRIW) || (opc == OP_ALRRW);
        if (opc == OP_LUI) begin
            return {{32{ins[31]}}, ins[31:12], 12'h000};
        end
        x = rs1v;
        y = (opc == OP_ALRI || opc == OP_ALRIW) ? {{52{ins[31]}}, ins[31:20]} : rs2v;
        // Word forms work on sign-extended low halves.
        if (word) begin
            x  = sext32(x[31:0]);
            y  = sext32(y[31:0]);
            sh = {1'b0, y[4:0]};
        end else begin
            sh = y[5:0];
        end
        case (f3)
            3'd0: r = (m && (opc == OP_ALRR || opc == OP_ALRRW)) ? x - y : x + y;
            3'd1: r = x << sh;
            3'd2: r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            3'd3: r = (x < y) ? 64'd1 : 64'd0;
            3'd4: r = x ^ y;
            3'd5: begin
                if (m) r = $signed(x) >>> sh;
                else if (word) r = {32'b0, x[31:0]} >> sh;
                else r = x >> sh;
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        // Upper half follows bit 31 in word forms.
        if (word) r = sext32(r[31:0]);
        return r;
    endfunction

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Ack is sampled away from the rising edge.
    task automatic wait_ack();
        @(negedge clk);
        while (!ack) @(negedge clk);
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] a, input xlen_t data);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= data;
        wait_ack();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] a, output xlen_t data);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_ack();
        data = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic write_reg(input int idx, input xlen_t data);
        wb_write(idx[ADR_W-1:0], data);
        if (idx != 0) model_regs[idx] = data;
    endtask

    // Upper word of the bus data is junk on purpose.
    task automatic run_instr(input instr_t ins);
        opcode_t opc;
        opc = ins[6:0];
        wb_write(INSTR_ADR[ADR_W-1:0], {next_rand(), ins});
        if ((opc == OP_ALRI || opc == OP_ALRR || opc == OP_ALRIW || opc == OP_ALRRW ||
             opc == OP_LUI) && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = ref_exec(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
        end
    endtask

    task automatic verify_all();
        xlen_t val;
        for (int i = 0; i < 32; i++) begin
            wb_read(i[ADR_W-1:0], val);
            check_value($sformatf("x%0d", i), val, model_regs[i]);
        end
    endtask

    // Register-register, word or double-word.
    function automatic instr_t rand_rr(input logic [31:0] r, input logic [31:0] q);
        return {1'b0, r[1], 5'b0, r[6:2], r[11:7], r[14:12], r[19:15],
                q[0] ? OP_ALRR : OP_ALRRW};
    endfunction

    // Register-immediate, shifts get a well-formed amount.
    function automatic instr_t rand_ri(input logic [31:0] r, input logic [31:0] q);
        logic [11:0] imm;
        opcode_t opc;
        opc = q[0] ? OP_ALRI : OP_ALRIW;
        imm = q[23:12];
        if (r[14:12] == 3'd1 || r[14:12] == 3'd5) begin
            imm = {1'b0, r[14:12] == 3'd5 && r[30], 4'b0, q[1] ? q[7:2] : {1'b0, q[6:2]}};
            if (opc == OP_ALRIW) imm[5] = 1'b0;
        end
        return {imm, r[11:7], r[14:12], r[19:15], opc};
    endfunction

    initial begin
        opcode_t bad_ops [N_BAD];
        logic [31:0] r;
        logic [31:0] q;
        xlen_t val;
        bad_ops = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b0010111, 7'b1101111, 7'b1110011};
        lcg_state = 32'h916;
        arst_n = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Register write and readback, x0 stays zero.
        for (int i = 0; i < 32; i++) write_reg(i, {next_rand(), next_rand()});
        verify_all();

        // OP and OP-32, operands refreshed now and then.
        for (int i = 0; i < N_RND; i++) begin
            if (i % 8 == 0) write_reg(1 + next_rand() % 31, {next_rand(), next_rand()});
            r = next_rand();
            q = next_rand();
            run_instr(rand_rr(r, q));
        end
        verify_all();

        // OP-IMM and OP-IMM-32.
        for (int i = 0; i < N_RND; i++) begin
            if (i % 8 == 0) write_reg(1 + next_rand() % 31, {next_rand(), next_rand()});
            r = next_rand();
            q = next_rand();
            run_instr(rand_ri(r, q));
        end
        verify_all();

        // LUI, then every form aimed at x0.
        for (int i = 0; i < N_LUI; i++) begin
            r = next_rand();
            run_instr({r[31:12], r[4:0] | 5'd1, OP_LUI});
        end
        r = next_rand();
        q = next_rand();
        run_instr({r[31:12], 5'd0, OP_LUI});
        run_instr(rand_rr(r, q) & ~32'h0000_0f80);
        run_instr(rand_rr(r, ~q) & ~32'h0000_0f80);
        run_instr(rand_ri(r, q) & ~32'h0000_0f80);
        run_instr(rand_ri(r, ~q) & ~32'h0000_0f80);
        verify_all();

        // Unsupported opcodes write nothing.
        for (int i = 0; i < N_BAD; i++) begin
            r = next_rand();
            run_instr({r[31:12], r[4:0] | 5'd1, bad_ops[i]});
        end
        wb_read(INSTR_ADR[ADR_W-1:0], val);
        check_value("instr_reg", val, '0);
        for (int a = INSTR_ADR + 1; a < (1 << ADR_W); a++) begin
            wb_write(a[ADR_W-1:0], {next_rand(), next_rand()});
            wb_read(a[ADR_W-1:0], val);
            check_value($sformatf("adr_%0d", a), val, '0);
        end
        verify_all();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rv_exec_pkg.sv
alu.sv
rv_decode.sv
rv_regfile.sv
rv_exec_unit.sv
rv_wb_slave.sv
rv_exec_top.sv
tb_rv_exec.sv
